/* logic/spike_geom_pkg.sv */
package spike_geom_pkg;

    //////////////////////////////////////////////////
    // pixel level types
    //////////////////////////////////////////////////

    // horizontal or vertical position on the screen
    typedef logic [11:0] pixel_coord_t;

    // 4 bits per channel, red in the top nibble
    typedef logic [11:0] rgb_t;

    //////////////////////////////////////////////////
    // game field
    //////////////////////////////////////////////////

    // vertical limits of the play area
    localparam pixel_coord_t field_top = 12'd317;
    localparam pixel_coord_t field_bottom = 12'd617;

    // every spike starts on this column
    localparam pixel_coord_t field_center_x = 12'd511;

    //////////////////////////////////////////////////
    // spike shape
    //////////////////////////////////////////////////

    // half of the triangle base, also the landing margin from the far edge
    localparam pixel_coord_t spike_half_width = 12'd20;

    // maximum height of the triangle measured from its base
    localparam pixel_coord_t spike_length = 12'd50;

    // inside when 3*dx + dy stays at or below this
    // gives a narrow tip pointing away from the starting edge
    localparam pixel_coord_t spike_tip = 12'd42;

    // mouse dead zone to the right of the pointer
    localparam pixel_coord_t follow_zone = spike_half_width / 2;

    // spike colours
    localparam rgb_t spike_rgb_white = 12'hfff;
    localparam rgb_t spike_rgb_red = 12'hf00;

endpackage

/* logic/spike_seq_pkg.sv */
package spike_seq_pkg;

    // kind of one step of the obstacle
    typedef enum logic [2:0] {
        none,
        single_top,
        single_bottom,
        barrage_top,
        barrage_bottom
    } step_kind_e;

    // sequencer states
    typedef enum logic [1:0] {
        idle,
        distribute,
        run
    } seq_state_e;

    typedef logic [4:0] step_count_t;
    typedef logic [25:0] tick_count_t;

    localparam step_count_t step_total = 5'd20;

    // menu code of this obstacle
    localparam logic [3:0] spike_game_code = 4'd5;

    // timing at 65 MHz pixel clock
    // one second of aim
    localparam tick_count_t aim_cycles_dflt = 26'd65_000_000;
    localparam tick_count_t move_cycles_dflt = 26'd300_000;
    localparam tick_count_t fast_move_cycles_dflt = 26'd150_000;
    // half a second of rest
    localparam tick_count_t settle_cycles_dflt = 26'd32_500_000;

    // fixed step order, index 0 runs first
    localparam step_kind_e step_pattern [step_total] = '{
        single_top, barrage_bottom, single_bottom, barrage_top, single_top,
        single_bottom, single_top, barrage_bottom, barrage_top, barrage_top,
        barrage_bottom, single_bottom, single_top, barrage_bottom, barrage_top,
        single_bottom, barrage_top, barrage_bottom, single_top, single_bottom
    };

    // spike enters from the top edge
    function automatic logic is_top_kind(step_kind_e kind);
        return (kind == single_top) || (kind == barrage_top);
    endfunction

    // barrages move on the fast tick
    function automatic logic is_barrage_kind(step_kind_e kind);
        return (kind == barrage_top) || (kind == barrage_bottom);
    endfunction

endpackage

/* logic/spike_sequencer.sv */
`timescale 1ns/10ps

module spike_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      done_in,
    input  logic                      play_selected,
    input  logic                      menu_on,
    input  logic [3:0]                selected,
    input  logic                      step_end,
    output spike_seq_pkg::step_kind_e step_kind,
    output logic                      load,
    output logic                      active,
    output logic                      done
);

    import spike_seq_pkg::*;

    seq_state_e  state;
    step_count_t step_idx;
    logic        start_hit;
    logic        abort;
    logic        steps_left;

    //////////////////////////////////////////////////
    // start and abort conditions
    //////////////////////////////////////////////////

    // previous obstacle finished and this one is chosen in the menu
    assign start_hit = done_in && (selected == spike_game_code) && play_selected;

    // leaving the game while spikes are on screen
    assign abort = menu_on || !play_selected;

    assign steps_left = (step_idx < step_total);

    //////////////////////////////////////////////////
    // step lookup
    //////////////////////////////////////////////////

    // index already points at the next step while distributing
    // and stays on the current one during run
    always_comb begin
        if (steps_left) begin
            step_kind = step_pattern[step_idx];
        end else begin
            step_kind = none;
        end
    end

    // one cycle of load per distribute visit with steps remaining
    assign load = (state == distribute) && steps_left;

    // motion and drawing only while a step is running
    assign active = (state == run);

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            step_idx <= '0;
            done     <= 1'b0;
        end else begin
            // done is a single cycle pulse
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start_hit) begin
                        state    <= distribute;
                        step_idx <= '0;
                    end
                end
                distribute: begin
                    if (!steps_left) begin
                        // all steps played, done rises with the first idle cycle
                        state <= idle;
                        done  <= 1'b1;
                    end else begin
                        state <= run;
                    end
                end
                run: begin
                    // abort keeps the step index and gives no done
                    if (abort) begin
                        state <= idle;
                    end else if (step_end) begin
                        state    <= distribute;
                        step_idx <= step_idx + 5'd1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* logic/spike_motion.sv */
`timescale 1ns/10ps

module spike_motion #(
    parameter spike_seq_pkg::tick_count_t aim_cycles       = spike_seq_pkg::aim_cycles_dflt,
    parameter spike_seq_pkg::tick_count_t move_cycles      = spike_seq_pkg::move_cycles_dflt,
    parameter spike_seq_pkg::tick_count_t fast_move_cycles =
        spike_seq_pkg::fast_move_cycles_dflt,
    parameter spike_seq_pkg::tick_count_t settle_cycles    = spike_seq_pkg::settle_cycles_dflt
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        load,
    input  logic                        active,
    input  spike_seq_pkg::step_kind_e   step_kind,
    input  spike_geom_pkg::pixel_coord_t mouse_x,
    output spike_geom_pkg::pixel_coord_t center_x,
    output spike_geom_pkg::pixel_coord_t center_y,
    output logic                        aiming,
    output logic                        step_end
);

    import spike_geom_pkg::*;
    import spike_seq_pkg::*;

    tick_count_t aim_cnt;
    tick_count_t x_tick;
    tick_count_t y_tick;
    tick_count_t settle_cnt;
    tick_count_t tick_period;
    logic        from_top;
    logic        follow_right;
    logic        follow_left;
    logic        x_step;
    logic        y_step;
    logic        landed;
    logic        settled;

    //////////////////////////////////////////////////
    // decode of the current step
    //////////////////////////////////////////////////

    assign from_top = is_top_kind(step_kind);

    // barrages run on the faster tick for both axes
    assign tick_period = is_barrage_kind(step_kind) ? fast_move_cycles : move_cycles;

    // pointer to the right of the spike
    assign follow_right = (center_x < mouse_x);
    // pointer left of the spike by more than the dead zone
    assign follow_left = ({1'b0, center_x} > ({1'b0, mouse_x} + {1'b0, follow_zone}));

    // a tick expires every tick_period+1 counted cycles
    assign x_step = (x_tick >= tick_period);
    assign y_step = (y_tick >= tick_period);

    // reached the margin at the opposite edge
    always_comb begin
        if (from_top) begin
            landed = (center_y >= (field_bottom - spike_half_width));
        end else begin
            landed = (center_y <= (field_top + spike_half_width));
        end
    end

    // single top spikes rest on the floor before the next step
    assign settled = (step_kind != single_top) || (settle_cnt == settle_cycles);

    assign step_end = active && !aiming && landed && settled;

    //////////////////////////////////////////////////
    // phase and tick counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            aiming     <= 1'b0;
            aim_cnt    <= '0;
            x_tick     <= '0;
            y_tick     <= '0;
            settle_cnt <= '0;
        end else if (load) begin
            // new step always begins with aim
            aiming     <= 1'b1;
            aim_cnt    <= '0;
            x_tick     <= '0;
            y_tick     <= '0;
            settle_cnt <= '0;
        end else if (active) begin
            if (aiming) begin
                // aim lasts aim_cycles+1 active cycles
                if (aim_cnt == aim_cycles) begin
                    aiming  <= 1'b0;
                    aim_cnt <= '0;
                end else begin
                    aim_cnt <= aim_cnt + 26'd1;
                end
                // inside the dead zone the x tick restarts
                if (follow_right || follow_left) begin
                    x_tick <= x_step ? '0 : x_tick + 26'd1;
                end else begin
                    x_tick <= '0;
                end
            end else if (landed) begin
                if ((step_kind == single_top) && !settled) begin
                    settle_cnt <= settle_cnt + 26'd1;
                end
            end else begin
                y_tick <= y_step ? '0 : y_tick + 26'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // spike centre
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            center_x <= field_center_x;
            center_y <= from_top ? field_top : field_bottom;
        end else if (active) begin
            if (aiming) begin
                // x only follows the mouse during aim
                if (x_step && follow_right) begin
                    center_x <= center_x + 12'd1;
                end else if (x_step && follow_left) begin
                    center_x <= center_x - 12'd1;
                end
            end else if (!landed && y_step) begin
                // fall towards the opposite edge
                center_y <= from_top ? center_y + 12'd1 : center_y - 12'd1;
            end
        end
    end

endmodule

/* logic/spike_renderer.sv */
`timescale 1ns/10ps

module spike_renderer (
    input  logic                         clk,
    input  logic                         rst,
    input  spike_geom_pkg::pixel_coord_t hcount,
    input  spike_geom_pkg::pixel_coord_t vcount,
    input  spike_geom_pkg::rgb_t         rgb_in,
    input  logic                         active,
    input  spike_seq_pkg::step_kind_e    step_kind,
    input  logic                         aiming,
    input  spike_geom_pkg::pixel_coord_t center_x,
    input  spike_geom_pkg::pixel_coord_t center_y,
    output spike_geom_pkg::rgb_t         rgb_out,
    output spike_geom_pkg::pixel_coord_t obstacle_x,
    output spike_geom_pkg::pixel_coord_t obstacle_y
);

    import spike_geom_pkg::*;
    import spike_seq_pkg::*;

    pixel_coord_t dx;
    pixel_coord_t dy;
    logic         beyond_base;
    logic         in_x;
    logic         in_y;
    logic         in_tip;
    logic         on_spike;
    logic [13:0]  tip_sum;
    rgb_t         spike_colour;

    //////////////////////////////////////////////////
    // triangle test
    //////////////////////////////////////////////////

    // horizontal distance, symmetric around the centre
    assign dx = (hcount >= center_x) ? (hcount - center_x) : (center_x - hcount);

    // vertical distance measured away from the starting edge
    always_comb begin
        if (is_top_kind(step_kind)) begin
            beyond_base = (vcount >= center_y);
            dy          = vcount - center_y;
        end else begin
            beyond_base = (vcount <= center_y);
            dy          = center_y - vcount;
        end
    end

    assign in_x = (dx <= spike_half_width);
    assign in_y = beyond_base && (dy <= spike_length);

    // 14 bits hold 3*4095 + 4095 without overflow
    assign tip_sum = (14'(dx) * 14'd3) + 14'(dy);
    assign in_tip = (tip_sum <= 14'(spike_tip));

    assign on_spike = active && in_x && in_y && in_tip;

    // barrages flash red while the player can still dodge
    assign spike_colour = (aiming && is_barrage_kind(step_kind)) ? spike_rgb_red
                                                                 : spike_rgb_white;

    //////////////////////////////////////////////////
    // output stage, one cycle of latency
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_out    <= '0;
            obstacle_x <= '0;
            obstacle_y <= '0;
        end else if (on_spike) begin
            rgb_out    <= spike_colour;
            // spike pixel goes to the collision check
            obstacle_x <= hcount;
            obstacle_y <= vcount;
        end else begin
            rgb_out    <= rgb_in;
            obstacle_x <= '0;
            obstacle_y <= '0;
        end
    end

endmodule

/* logic/falling_spikes_obstacle.sv */
`timescale 1ns/10ps

module falling_spikes_obstacle #(
    parameter spike_seq_pkg::tick_count_t aim_cycles       = spike_seq_pkg::aim_cycles_dflt,
    parameter spike_seq_pkg::tick_count_t move_cycles      = spike_seq_pkg::move_cycles_dflt,
    parameter spike_seq_pkg::tick_count_t fast_move_cycles =
        spike_seq_pkg::fast_move_cycles_dflt,
    parameter spike_seq_pkg::tick_count_t settle_cycles    = spike_seq_pkg::settle_cycles_dflt
) (
    input  logic                         clk,
    input  logic                         rst,
    input  spike_geom_pkg::pixel_coord_t hcount,
    input  spike_geom_pkg::pixel_coord_t vcount,
    input  spike_geom_pkg::rgb_t         rgb_in,
    input  spike_geom_pkg::pixel_coord_t mouse_x,
    input  logic                         done_in,
    input  logic                         play_selected,
    input  logic                         menu_on,
    input  logic [3:0]                   selected,
    output spike_geom_pkg::rgb_t         rgb_out,
    output spike_geom_pkg::pixel_coord_t obstacle_x,
    output spike_geom_pkg::pixel_coord_t obstacle_y,
    output logic                         done
);

    import spike_geom_pkg::*;
    import spike_seq_pkg::*;

    // sequencer to motion and renderer
    step_kind_e   step_kind;
    logic         load;
    logic         active;

    // motion to renderer and sequencer
    pixel_coord_t center_x;
    pixel_coord_t center_y;
    logic         aiming;
    logic         step_end;

    spike_sequencer spike_sequencer_inst (
        .clk           (clk),
        .rst           (rst),
        .done_in       (done_in),
        .play_selected (play_selected),
        .menu_on       (menu_on),
        .selected      (selected),
        .step_end      (step_end),
        .step_kind     (step_kind),
        .load          (load),
        .active        (active),
        .done          (done)
    );

    spike_motion #(
        .aim_cycles       (aim_cycles),
        .move_cycles      (move_cycles),
        .fast_move_cycles (fast_move_cycles),
        .settle_cycles    (settle_cycles)
    ) spike_motion_inst (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .active    (active),
        .step_kind (step_kind),
        .mouse_x   (mouse_x),
        .center_x  (center_x),
        .center_y  (center_y),
        .aiming    (aiming),
        .step_end  (step_end)
    );

    spike_renderer spike_renderer_inst (
        .clk        (clk),
        .rst        (rst),
        .hcount     (hcount),
        .vcount     (vcount),
        .rgb_in     (rgb_in),
        .active     (active),
        .step_kind  (step_kind),
        .aiming     (aiming),
        .center_x   (center_x),
        .center_y   (center_y),
        .rgb_out    (rgb_out),
        .obstacle_x (obstacle_x),
        .obstacle_y (obstacle_y)
    );

endmodule

/* dv/falling_spikes_assertions.sv */
`timescale 1ns/10ps

module falling_spikes_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         done,
    input logic                         active,
    input spike_geom_pkg::rgb_t         rgb_in,
    input spike_geom_pkg::rgb_t         rgb_out,
    input spike_geom_pkg::pixel_coord_t obstacle_x,
    input spike_geom_pkg::pixel_coord_t obstacle_y
);

    import spike_geom_pkg::*;

    //////////////////////////////////////////////////
    // protocol of the top level outputs
    //////////////////////////////////////////////////

    // done is a single cycle pulse
    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done high for two cycles in a row");

    // a reported spike pixel either replaced the colour or carries a spike colour
    coords_with_spike: assert property (@(posedge clk) disable iff (rst)
        ((obstacle_x != '0) || (obstacle_y != '0)) |->
            ((rgb_out != $past(rgb_in)) || (rgb_out == spike_rgb_white)
             || (rgb_out == spike_rgb_red)))
        else $error("obstacle coordinates without a spike colour");

    // no step running, so nothing drawn one cycle later
    idle_no_draw: assert property (@(posedge clk) disable iff (rst)
        !active |=> ((obstacle_x == '0) && (obstacle_y == '0)))
        else $error("spike drawn while no step was running");

endmodule

bind falling_spikes_obstacle falling_spikes_assertions falling_spikes_assertions_inst (
    .clk        (clk),
    .rst        (rst),
    .done       (done),
    .active     (active),
    .rgb_in     (rgb_in),
    .rgb_out    (rgb_out),
    .obstacle_x (obstacle_x),
    .obstacle_y (obstacle_y)
);

/* dv/falling_spikes_tb.sv */
`timescale 1ns/10ps

module falling_spikes_tb;

    import spike_geom_pkg::*;
    import spike_seq_pkg::*;

    // short timing for the DUT
    localparam int aim_len    = 40;
    localparam int move_len   = 3;
    localparam int fast_len   = 1;
    localparam int settle_len = 10;

    // worst step: distribute, aim, a full field on the slow tick, settle, one spare
    localparam int field_height = int'(field_bottom) - int'(field_top);
    localparam int step_worst   = 2 + (aim_len + 1) + field_height * (move_len + 1)
                                  + settle_len + 1;
    // two runs of all steps plus margin for gating and idle phases
    localparam int watchdog_cycles = 2 * int'(step_total) * step_worst + 5000;

    logic         clk;
    logic         rst;
    pixel_coord_t hcount;
    pixel_coord_t vcount;
    rgb_t         rgb_in;
    pixel_coord_t mouse_x;
    logic         done_in;
    logic         play_selected;
    logic         menu_on;
    logic [3:0]   selected;
    rgb_t         rgb_out;
    pixel_coord_t obstacle_x;
    pixel_coord_t obstacle_y;
    logic         done;

    // cycle model of sequencer and motion
    seq_state_e   m_state = idle;
    int           m_idx = 0;
    logic         m_done = 1'b0;
    logic         m_aiming = 1'b0;
    int           m_aim_cnt = 0;
    int           m_xt = 0;
    int           m_yt = 0;
    int           m_settle = 0;
    int           m_cx = 511;
    int           m_cy = 317;

    // outputs expected after the last rising edge
    rgb_t         exp_rgb = '0;
    pixel_coord_t exp_x = '0;
    pixel_coord_t exp_y = '0;
    logic         exp_done = 1'b0;

    logic         check_on = 1'b0;
    int           err_count = 0;
    int           check_count = 0;
    int           done_seen = 0;
    int           spike_pix = 0;
    int           red_pix = 0;
    int           white_pix = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           cyc = 0;

    falling_spikes_obstacle #(
        .aim_cycles       (26'(aim_len)),
        .move_cycles      (26'(move_len)),
        .fast_move_cycles (26'(fast_len)),
        .settle_cycles    (26'(settle_len))
    ) falling_spikes_obstacle_inst (
        .clk           (clk),
        .rst           (rst),
        .hcount        (hcount),
        .vcount        (vcount),
        .rgb_in        (rgb_in),
        .mouse_x       (mouse_x),
        .done_in       (done_in),
        .play_selected (play_selected),
        .menu_on       (menu_on),
        .selected      (selected),
        .rgb_out       (rgb_out),
        .obstacle_x    (obstacle_x),
        .obstacle_y    (obstacle_y),
        .done          (done)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // reference rules
    //////////////////////////////////////////////////

    // step order, grouped by kind
    function automatic step_kind_e kind_at(int idx);
        case (idx)
            0, 4, 6, 12, 18:  return single_top;
            3, 8, 9, 14, 16:  return barrage_top;
            2, 5, 11, 15, 19: return single_bottom;
            1, 7, 10, 13, 17: return barrage_bottom;
            default:          return none;
        endcase
    endfunction

    // triangle membership around the spike centre
    function automatic logic inside_spike(int h, int v, int cx, int cy, logic top);
        int dx;
        int dy;
        dx = (h >= cx) ? h - cx : cx - h;
        // distance away from the starting edge
        dy = top ? v - cy : cy - v;
        return (dx <= int'(spike_half_width)) && (dy >= 0) && (dy <= int'(spike_length))
               && (3 * dx + dy <= int'(spike_tip));
    endfunction

    always @(posedge clk) begin : model
        step_kind_e kind;
        logic       top;
        logic       barrage;
        logic       act;
        logic       ld;
        logic       landed;
        logic       settled;
        logic       step_end;
        logic       go_right;
        logic       go_left;
        logic       x_step;
        logic       y_step;
        int         tick;
        kind     = kind_at(m_idx);
        top      = (kind == single_top) || (kind == barrage_top);
        barrage  = (kind == barrage_top) || (kind == barrage_bottom);
        act      = (m_state == run);
        ld       = (m_state == distribute) && (m_idx < int'(step_total));
        tick     = barrage ? fast_len : move_len;
        landed   = top ? (m_cy >= int'(field_bottom) - int'(spike_half_width))
                       : (m_cy <= int'(field_top) + int'(spike_half_width));
        settled  = (kind != single_top) || (m_settle == settle_len);
        step_end = act && !m_aiming && landed && settled;
        go_right = m_cx < int'(mouse_x);
        go_left  = m_cx > int'(mouse_x) + int'(follow_zone);
        x_step   = m_xt >= tick;
        y_step   = m_yt >= tick;

        // renderer, one cycle behind the pixel
        if (rst) begin
            exp_rgb = '0;
            exp_x   = '0;
            exp_y   = '0;
        end else if (act && inside_spike(int'(hcount), int'(vcount), m_cx, m_cy, top)) begin
            exp_rgb = (m_aiming && barrage) ? spike_rgb_red : spike_rgb_white;
            exp_x   = hcount;
            exp_y   = vcount;
        end else begin
            exp_rgb = rgb_in;
            exp_x   = '0;
            exp_y   = '0;
        end

        // motion
        if (rst) begin
            m_aiming  = 1'b0;
            m_aim_cnt = 0;
            m_xt      = 0;
            m_yt      = 0;
            m_settle  = 0;
        end else if (ld) begin
            m_aiming  = 1'b1;
            m_aim_cnt = 0;
            m_xt      = 0;
            m_yt      = 0;
            m_settle  = 0;
            m_cx      = int'(field_center_x);
            m_cy      = top ? int'(field_top) : int'(field_bottom);
        end else if (act) begin
            if (m_aiming) begin
                if (m_aim_cnt == aim_len) begin
                    m_aiming  = 1'b0;
                    m_aim_cnt = 0;
                end else begin
                    m_aim_cnt++;
                end
                m_xt = (go_right || go_left) ? (x_step ? 0 : m_xt + 1) : 0;
                if (x_step && go_right) m_cx++;
                else if (x_step && go_left) m_cx--;
            end else if (landed) begin
                // only single top spikes can be unsettled
                if (!settled) m_settle++;
            end else begin
                m_yt = y_step ? 0 : m_yt + 1;
                if (y_step) m_cy = top ? m_cy + 1 : m_cy - 1;
            end
        end

        // sequencer
        m_done = 1'b0;
        if (rst) begin
            m_state = idle;
            m_idx   = 0;
        end else if (m_state == idle) begin
            if (done_in && (selected == 4'd5) && play_selected) begin
                m_state = distribute;
                m_idx   = 0;
            end
        end else if (m_state == distribute) begin
            if (m_idx >= int'(step_total)) begin
                m_state = idle;
                m_done  = 1'b1;
            end else begin
                m_state = run;
            end
        end else if (menu_on || !play_selected) begin
            m_state = idle;
        end else if (step_end) begin
            m_state = distribute;
            m_idx++;
        end
        exp_done = m_done;
    end

    //////////////////////////////////////////////////
    // comparator, outputs are stable on the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (check_on) begin
            check_count++;
            assert (rgb_out == exp_rgb) else begin
                err_count++;
                $display("ERR %0t: rgb_out %h, expected %h", $time, rgb_out, exp_rgb);
            end
            assert ((obstacle_x == exp_x) && (obstacle_y == exp_y)) else begin
                err_count++;
                $display("ERR %0t: obstacle at %0d,%0d, expected %0d,%0d", $time,
                         obstacle_x, obstacle_y, exp_x, exp_y);
            end
            assert (done == exp_done) else begin
                err_count++;
                $display("ERR %0t: done %b, expected %b", $time, done, exp_done);
            end
            if (done) done_seen++;
            if ((obstacle_x != '0) || (obstacle_y != '0)) begin
                spike_pix++;
                if (rgb_out == spike_rgb_red) red_pix++;
                if (rgb_out == spike_rgb_white) white_pix++;
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // half of the pixels near the spike, the rest anywhere on screen
    task automatic drive_cycle();
        @(negedge clk);
        cyc++;
        if ($urandom_range(1, 0) == 1) begin
            hcount = pixel_coord_t'(m_cx - 14 + int'($urandom_range(28, 0)));
            vcount = pixel_coord_t'(m_cy - 45 + int'($urandom_range(90, 0)));
        end else begin
            hcount = pixel_coord_t'($urandom_range(1023, 0));
            vcount = pixel_coord_t'($urandom_range(767, 0));
        end
        rgb_in = rgb_t'($urandom);
        // pointer wanders around the start column
        if (cyc % 8 == 0) begin
            mouse_x = pixel_coord_t'(int'(field_center_x) - 40 + int'($urandom_range(80, 0)));
        end
    endtask

    task automatic run_cycles(int n);
        repeat (n) drive_cycle();
    endtask

    task automatic expect_true(logic cond, string what);
        assert (cond) else begin
            err_count++;
            $display("check failed at %0t: %s", $time, what);
        end
    endtask

    task automatic finish_test(string name, int errs_before);
        // between falling edges, so the comparator is quiet
        @(posedge clk);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic pulse_done_in();
        done_in = 1'b1;
        drive_cycle();
        done_in = 1'b0;
    endtask

    initial begin : stimulus
        int errs_before;
        int settle_hits;
        int spike_mark;
        void'($urandom(32'ha80c_4fba));
        rst           = 1'b1;
        hcount        = '0;
        vcount        = '0;
        rgb_in        = '0;
        mouse_x       = field_center_x;
        done_in       = 1'b0;
        play_selected = 1'b1;
        menu_on       = 1'b0;
        selected      = 4'd0;
        settle_hits   = 0;
        repeat (3) @(posedge clk);
        check_on = 1'b1;
        @(negedge clk);
        rst = 1'b0;

        // reset values, then plain pass-through
        errs_before = err_count;
        expect_true((done == 1'b0) && (obstacle_x == '0) && (obstacle_y == '0),
                    "outputs not cleared by reset");
        run_cycles(30);
        finish_test("reset_idle", errs_before);

        // wrong code, then play not selected, then a valid start
        errs_before = err_count;
        drive_cycle();
        selected = 4'd3;
        pulse_done_in();
        run_cycles(10);
        selected      = 4'd5;
        play_selected = 1'b0;
        pulse_done_in();
        run_cycles(10);
        expect_true(spike_pix == 0, "spike drawn without a valid start");
        play_selected = 1'b1;
        pulse_done_in();
        while (m_state != run) drive_cycle();
        run_cycles(60);
        expect_true(spike_pix > 0, "no spike pixels after a valid start");
        finish_test("start_gating", errs_before);

        // aim of single and barrage steps with a moving pointer
        errs_before = err_count;
        while (m_idx < 4) drive_cycle();
        expect_true(red_pix > 0, "no red barrage pixels during aim");
        expect_true(white_pix > 0, "no white spike pixels");
        finish_test("aim", errs_before);

        // remaining steps through all kinds
        errs_before = err_count;
        while (m_idx < 19) begin
            drive_cycle();
            // resting spike reported while the model still settles
            if ((m_settle > 0) && (obstacle_x != '0)) settle_hits++;
            if ((m_state == run) && (m_settle > 0)) begin
                // probe the base centre of the resting spike
                hcount = pixel_coord_t'(m_cx);
                vcount = pixel_coord_t'(m_cy);
            end
        end
        expect_true(settle_hits > 0, "no spike drawn during the settle rest");
        finish_test("fall_landing", errs_before);

        // last step, done pulse and return to pass-through
        errs_before = err_count;
        while (done !== 1'b1) drive_cycle();
        spike_mark = spike_pix;
        run_cycles(20);
        expect_true(done_seen == 1, "done pulse count is not one");
        expect_true(m_idx == int'(step_total), "done before the last step");
        expect_true(spike_pix == spike_mark, "spike drawn after done");
        finish_test("completion", errs_before);

        // abort in the fall phase of the first step
        errs_before = err_count;
        drive_cycle();
        pulse_done_in();
        while (m_state != run) drive_cycle();
        run_cycles(60);
        menu_on = 1'b1;
        run_cycles(2);
        spike_mark = spike_pix;
        run_cycles(30);
        expect_true(spike_pix == spike_mark, "spike still drawn after menu abort");
        menu_on = 1'b0;
        run_cycles(10);
        expect_true(done_seen == 1, "done pulse after an abort");
        finish_test("abort", errs_before);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if ((err_count == 0) && (tests_failed == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* flist.f */
logic/spike_geom_pkg.sv
logic/spike_seq_pkg.sv
logic/spike_sequencer.sv
logic/spike_motion.sv
logic/spike_renderer.sv
logic/falling_spikes_obstacle.sv
dv/falling_spikes_assertions.sv
dv/falling_spikes_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the falling spikes testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module falling_spikes_tb \
    -f flist.f \
    -o sim_falling_spikes

# the log decides the result, not the simulator exit code
./obj_dir/sim_falling_spikes 2>&1 | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see sim.log"
exit 1
